// ==== Bender.yml ====
package:
  name: dma_bus_master

sources:
  - hdl/dmaPkg.sv
  - hdl/dmaRegs.sv
  - hdl/cpuBusSync.sv
  - hdl/cpuBusSm.sv
  - hdl/dmaFifo.sv
  - hdl/dmaTop.sv
  - target: simulation
    files:
      - sim/cpuBusSm_properties.sv
      - sim/dmaTb.sv

// ==== files.f ====
hdl/dmaPkg.sv
hdl/dmaRegs.sv
hdl/cpuBusSync.sv
hdl/cpuBusSm.sv
hdl/dmaFifo.sv
hdl/dmaTop.sv
sim/cpuBusSm_properties.sv
sim/dmaTb.sv

// ==== hdl/cpuBusSm.sv ====
// Bus master state machine
`timescale 1ns/100ps

module cpuBusSm (
    input  logic                            CLK135,
    input  logic                            CCRESET_,
    input  dmaPkg::dmaCfg_t                 cfg,
    input  dmaPkg::busIn_t                  busIn,
    input  logic [dmaPkg::LevelWidth-1:0]   fifoLevel,
    input  logic                            fifoEmpty,
    output dmaPkg::busCtl_t                 busNext,
    output logic                            wordDone,
    output logic                            fifoPush,
    output logic                            fifoPop
);
    import dmaPkg::*;

    smState_t                 state;
    smState_t                 stateNext;
    logic [BurstCntWidth-1:0] burstCnt;
    logic                     startWrite;
    logic                     startRead;
    logic                     lastWord;

    // peripheral to memory: a full burst, or anything left when flushing
    assign startWrite = !cfg.dir
        && (fifoLevel >= LevelWidth'(BurstWords) || (cfg.flush && !fifoEmpty));

    // memory to peripheral: room for a full burst
    assign startRead = cfg.dir && fifoLevel <= LevelWidth'(FifoDepth - BurstWords);

    // tenure ends on burst size, or FIFO drained / filled by this word
    assign lastWord = burstCnt == BurstCntWidth'(BurstWords - 1)
        || (cfg.dir ? fifoLevel >= LevelWidth'(FifoDepth - 1)
                    : fifoLevel <= LevelWidth'(1));

    always_comb begin
        stateNext = state;
        busNext   = '0;
        wordDone  = 1'b0;
        fifoPush  = 1'b0;
        fifoPop   = 1'b0;
        case (state)
            Idle: begin
                if (cfg.active && (startWrite || startRead)) begin
                    stateNext = Request;
                end
            end
            Request: begin
                busNext.breq = 1'b1;
                if (busIn.grant) begin
                    stateNext = Own;
                end
            end
            Own: begin
                busNext.bgack = 1'b1;  // breq drops here
                stateNext     = Addr;
            end
            Addr: begin
                busNext.bgack = 1'b1;
                if (cfg.active) begin
                    busNext.pas = 1'b1;
                    busNext.rw  = cfg.dir;
                    stateNext   = Data;
                end else begin
                    stateNext = Release;  // count ran out
                end
            end
            Data: begin
                busNext.bgack = 1'b1;
                busNext.pas   = 1'b1;
                busNext.rw    = cfg.dir;
                busNext.pds   = 1'b1;
                if (busIn.cycleDone) begin
                    wordDone    = 1'b1;
                    fifoPush    = cfg.dir;
                    fifoPop     = !cfg.dir;
                    busNext.pds = 1'b0;
                    busNext.pas = !lastWord;
                    busNext.rw  = cfg.dir && !lastWord;
                    stateNext   = lastWord ? Release : Addr;
                end
            end
            Release: begin
                stateNext = Idle;  // bgack low for one cycle
            end
            default: begin
                stateNext = Idle;
            end
        endcase
    end

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state <= Idle;
        end else begin
            state <= stateNext;
        end
    end

    // words moved in the current tenure
    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            burstCnt <= '0;
        end else if (state == Own) begin
            burstCnt <= '0;
        end else if (state == Data && busIn.cycleDone) begin
            burstCnt <= burstCnt + BurstCntWidth'(1);
        end
    end

endmodule

// ==== hdl/cpuBusSync.sv ====
// Bus input synchronizer and output registers
`timescale 1ns/100ps

module cpuBusSync (
    input  logic            CLK135,
    input  logic            CCRESET_,
    input  logic            bgrant_,
    input  logic            dsack_,
    input  logic            sterm_,
    input  dmaPkg::busCtl_t busNext,
    output dmaPkg::busIn_t  busIn,
    output dmaPkg::busCtl_t bus
);

    logic [2:0] inMeta;   // {bgrant_, dsack_, sterm_}
    logic [2:0] inSync;
    logic       ackLevel;
    logic       ackSeen;

    // two flops per async input, idle high
    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            inMeta <= 3'b111;
            inSync <= 3'b111;
        end else begin
            inMeta <= {bgrant_, dsack_, sterm_};
            inSync <= inMeta;
        end
    end

    assign ackLevel = !inSync[1] || !inSync[0];  // dsack or sterm

    // one done per acknowledge; wait for the slave to release before the next
    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            ackSeen <= 1'b0;
        end else if (busIn.cycleDone) begin
            ackSeen <= 1'b1;
        end else if (!ackLevel) begin
            ackSeen <= 1'b0;
        end
    end

    assign busIn.grant     = !inSync[2];
    assign busIn.cycleDone = bus.pas && ackLevel && !ackSeen;  // only with strobe out

    // control outputs, inactive out of reset
    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            bus <= '0;
        end else begin
            bus <= busNext;
        end
    end

endmodule

// ==== hdl/dmaFifo.sv ====
// DMA word FIFO
`timescale 1ns/100ps

module dmaFifo (
    input  logic                            CLK135,
    input  logic                            CCRESET_,
    input  logic                            pushEn,
    input  logic                            popEn,
    input  logic [dmaPkg::WordWidth-1:0]    wData,
    output logic [dmaPkg::WordWidth-1:0]    rData,
    output logic [dmaPkg::LevelWidth-1:0]   level,
    output logic                            empty,
    output logic                            full
);
    import dmaPkg::*;

    logic [WordWidth-1:0] mem [FifoDepth];
    logic [PtrWidth-1:0]  wrPtr;
    logic [PtrWidth-1:0]  rdPtr;
    logic                 doPush;
    logic                 doPop;

    assign doPush = pushEn && !full;   // overflow dropped
    assign doPop  = popEn && !empty;   // underflow dropped

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + PtrWidth'(1);  // wraps at depth
            end
            if (doPop) begin
                rdPtr <= rdPtr + PtrWidth'(1);
            end
            if (doPush && !doPop) begin
                level <= level + LevelWidth'(1);
            end else if (doPop && !doPush) begin
                level <= level - LevelWidth'(1);
            end
        end
    end

    always_ff @(posedge CLK135) begin
        if (doPush) begin
            mem[wrPtr] <= wData;
        end
    end

    assign rData = mem[rdPtr];  // head, same cycle
    assign empty = level == '0;
    assign full  = level == LevelWidth'(FifoDepth);

endmodule

// ==== hdl/dmaPkg.sv ====
// DMA shared definitions
package dmaPkg;

    localparam int WordWidth  = 32;
    localparam int AddrWidth  = 32;
    localparam int CountWidth = 16;
    localparam int FifoDepth  = 8;
    localparam int BurstWords = 4;  // words per bus tenure

    localparam int PtrWidth      = $clog2(FifoDepth);
    localparam int LevelWidth    = $clog2(FifoDepth + 1);
    localparam int BurstCntWidth = $clog2(BurstWords);

    typedef struct packed {
        logic                 dir;     // 1 = memory to peripheral
        logic                 active;  // enabled and count not zero
        logic                 flush;   // drain below burst size
        logic [AddrWidth-1:0] addr;    // current bus address
    } dmaCfg_t;

    typedef struct packed {
        logic breq;
        logic bgack;
        logic pas;
        logic pds;
        logic rw;   // 1 = read
    } busCtl_t;

    typedef struct packed {
        logic grant;
        logic cycleDone;
    } busIn_t;

    typedef enum logic [2:0] {
        Idle,
        Request,
        Own,
        Addr,
        Data,
        Release
    } smState_t;

endpackage

// ==== hdl/dmaRegs.sv ====
// DMA register block
`timescale 1ns/100ps

module dmaRegs (
    input  logic                           CLK135,
    input  logic                           CCRESET_,
    input  logic                           regWr,
    input  logic [1:0]                     regAddr,
    input  logic [dmaPkg::WordWidth-1:0]   regWData,
    output logic [dmaPkg::WordWidth-1:0]   regRData,
    input  logic                           wordDone,
    output dmaPkg::dmaCfg_t                cfg,
    output logic                           dmaDone
);
    import dmaPkg::*;

    logic                  dir;
    logic                  enable;
    logic                  flush;
    logic [AddrWidth-1:0]  addr;
    logic [CountWidth-1:0] count;

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dir     <= 1'b0;
            enable  <= 1'b0;
            flush   <= 1'b0;
            addr    <= '0;
            count   <= '0;
            dmaDone <= 1'b0;
        end else begin
            if (regWr && regAddr == 2'd0) begin
                {flush, enable, dir} <= regWData[2:0];
                dmaDone              <= 1'b0;  // control write acks the interrupt
            end else if (wordDone && count == CountWidth'(1)) begin
                dmaDone <= 1'b1;
            end
            if (regWr && regAddr == 2'd1) begin
                addr <= regWData[AddrWidth-1:0];
            end else if (wordDone) begin
                addr <= addr + AddrWidth'(4);  // long-word step
            end
            if (regWr && regAddr == 2'd2) begin
                count <= regWData[CountWidth-1:0];
            end else if (wordDone && count != '0) begin
                count <= count - CountWidth'(1);
            end
        end
    end

    always_comb begin
        case (regAddr)
            2'd0:    regRData = {{(WordWidth-4){1'b0}}, dmaDone, flush, enable, dir};
            2'd1:    regRData = addr;
            2'd2:    regRData = {{(WordWidth-CountWidth){1'b0}}, count};
            default: regRData = '0;
        endcase
    end

    assign cfg.dir    = dir;
    assign cfg.active = enable && (count != '0);
    assign cfg.flush  = flush;
    assign cfg.addr   = addr;

endmodule

// ==== hdl/dmaTop.sv ====
// DMA bus master top level
`timescale 1ns/100ps

module dmaTop (
    input  logic                           CLK135,
    input  logic                           CCRESET_,
    input  logic                           regWr,
    input  logic [1:0]                     regAddr,
    input  logic [dmaPkg::WordWidth-1:0]   regWData,
    output logic [dmaPkg::WordWidth-1:0]   regRData,
    input  logic                           periphPush,
    input  logic [dmaPkg::WordWidth-1:0]   periphWData,
    input  logic                           periphPop,
    output logic [dmaPkg::WordWidth-1:0]   periphRData,
    input  logic                           bgrant_,
    input  logic                           dsack_,
    input  logic                           sterm_,
    input  logic [dmaPkg::WordWidth-1:0]   busDataIn,
    output dmaPkg::busCtl_t                bus,
    output logic [dmaPkg::AddrWidth-1:0]   busAddr,
    output logic [dmaPkg::WordWidth-1:0]   busDataOut,
    output logic                           dmaDone
);
    import dmaPkg::*;

    dmaCfg_t               cfg;
    busCtl_t               busNext;
    busIn_t                busIn;
    logic                  wordDone;
    logic                  smPush;
    logic                  smPop;
    logic                  fifoPushEn;
    logic                  fifoPopEn;
    logic [WordWidth-1:0]  fifoWData;
    logic [WordWidth-1:0]  fifoRData;
    logic [LevelWidth-1:0] fifoLevel;
    logic                  fifoEmpty;
    logic                  fifoFull;

    dmaRegs dmaRegs_i (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_),
        .regWr    (regWr),
        .regAddr  (regAddr),
        .regWData (regWData),
        .regRData (regRData),
        .wordDone (wordDone),
        .cfg      (cfg),
        .dmaDone  (dmaDone)
    );

    cpuBusSync cpuBusSync_i (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_),
        .bgrant_  (bgrant_),
        .dsack_   (dsack_),
        .sterm_   (sterm_),
        .busNext  (busNext),
        .busIn    (busIn),
        .bus      (bus)
    );

    cpuBusSm cpuBusSm_i (
        .CLK135    (CLK135),
        .CCRESET_  (CCRESET_),
        .cfg       (cfg),
        .busIn     (busIn),
        .fifoLevel (fifoLevel),
        .fifoEmpty (fifoEmpty),
        .busNext   (busNext),
        .wordDone  (wordDone),
        .fifoPush  (smPush),
        .fifoPop   (smPop)
    );

    // write side fed by peripheral (dir 0) or bus (dir 1)
    assign fifoPushEn = cfg.dir ? smPush : periphPush && !fifoFull;
    assign fifoWData  = cfg.dir ? busDataIn : periphWData;
    assign fifoPopEn  = cfg.dir ? periphPop : smPop;

    dmaFifo dmaFifo_i (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_),
        .pushEn   (fifoPushEn),
        .popEn    (fifoPopEn),
        .wData    (fifoWData),
        .rData    (fifoRData),
        .level    (fifoLevel),
        .empty    (fifoEmpty),
        .full     (fifoFull)
    );

    assign periphRData = fifoRData;
    assign busDataOut  = fifoRData;  // head word during write cycles
    assign busAddr     = cfg.addr;

endmodule

// ==== sim/cpuBusSm_properties.sv ====
// Bus master protocol assertions
`timescale 1ns/100ps

module cpuBusSm_properties (
    input logic             CLK135,
    input logic             CCRESET_,
    input dmaPkg::busCtl_t  busNext,
    input dmaPkg::smState_t state,
    input logic             wordDone
);
    import dmaPkg::*;

    int failCount = 0;  // failed assertions so far

    // data strobe only inside a tenure
    pdsInTenure: assert property (@(posedge CLK135) disable iff (!CCRESET_)
        busNext.pds |-> busNext.bgack)
        else begin
            $error("pds asserted without bgack");
            failCount++;
        end

    strobeNoReq: assert property (@(posedge CLK135) disable iff (!CCRESET_)
        (busNext.pas || busNext.pds) |-> !busNext.breq)
        else begin
            $error("address or data strobe while breq is high");
            failCount++;
        end

    doneInData: assert property (@(posedge CLK135) disable iff (!CCRESET_)
        wordDone |-> state == Data)
        else begin
            $error("wordDone outside the Data state");
            failCount++;
        end

endmodule

bind cpuBusSm cpuBusSm_properties cpuBusSmProps (
    .CLK135   (CLK135),
    .CCRESET_ (CCRESET_),
    .busNext  (busNext),
    .state    (state),
    .wordDone (wordDone)
);

// ==== sim/dmaTb.sv ====
// DMA subsystem testbench
`timescale 1ns/100ps

module dmaTb;
    import dmaPkg::*;

    localparam int MaxCycles = 4000;  // several times the whole test length
    localparam int DoneWait  = 600;   // per transfer
    localparam logic [31:0] Base2 = 32'h0000_1000;
    localparam logic [31:0] Base3 = 32'h0000_2000;
    localparam logic [31:0] Base4 = 32'h0000_3000;
    localparam logic [31:0] Base5 = 32'h0000_4000;

    logic                 CLK135;
    logic                 CCRESET_;
    logic                 regWr;
    logic [1:0]           regAddr;
    logic [WordWidth-1:0] regWData;
    logic [WordWidth-1:0] regRData;
    logic                 periphPush;
    logic [WordWidth-1:0] periphWData;
    logic                 periphPop;
    logic [WordWidth-1:0] periphRData;
    logic                 bgrant_;
    logic                 dsack_;
    logic                 sterm_;
    logic [WordWidth-1:0] busDataIn;
    busCtl_t              bus;
    logic [AddrWidth-1:0] busAddr;
    logic [WordWidth-1:0] busDataOut;
    logic                 dmaDone;

    logic [WordWidth-1:0] memArr [logic [AddrWidth-1:0]];  // bus memory
    integer seed;
    int     cycleCount = 0;
    int     errCount = 0;
    int     checkCount = 0;
    int     grantCnt;
    int     ackWait;
    logic   ackOut;
    int     tenures = 0;
    int     earlyReq = 0;
    int     memWrites = 0;
    logic   breqLast = 1'b0;
    logic   bgackLast = 1'b0;

    dmaTop dmaTop_i (.*);

    initial begin
        CLK135 = 1'b0;
        forever #50 CLK135 = ~CLK135;
    end

    always @(posedge CLK135) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            $display("timeout: the run did not finish within %0d cycles", MaxCycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] memRead(input logic [31:0] addr);
        if (memArr.exists(addr)) begin
            return memArr[addr];
        end
        return addr ^ 32'h5A5A_A5A5;  // unwritten locations
    endfunction

    // memory slave and arbiter
    always @(posedge CLK135) begin
        if (CCRESET_) begin
            if (bus.breq) begin
                grantCnt <= grantCnt + 1;
                if (grantCnt == 1) begin
                    bgrant_ <= 1'b0;  // grant 2 cycles after breq
                end
            end else begin
                grantCnt <= 0;
                bgrant_  <= 1'b1;
            end
            if (bus.pds && !ackOut) begin
                if (ackWait == 0) begin
                    dsack_ <= 1'b0;
                    ackOut <= 1'b1;
                    if (bus.rw) begin
                        busDataIn <= memRead(busAddr);
                    end else begin
                        memArr[busAddr] = busDataOut;
                        memWrites <= memWrites + 1;
                    end
                end else begin
                    ackWait <= ackWait - 1;  // slow memory
                end
            end else if (!bus.pds && ackOut) begin
                dsack_  <= 1'b1;
                ackOut  <= 1'b0;
                ackWait <= $unsigned($random(seed)) % 4;
            end
        end
    end

    // tenure count and early request watch
    always @(posedge CLK135) begin
        if (CCRESET_) begin
            if (bus.breq && !breqLast && !dmaTop_i.cfg.dir && !dmaTop_i.cfg.flush
                && dmaTop_i.fifoLevel < LevelWidth'(BurstWords)) begin
                earlyReq <= earlyReq + 1;
            end
            if (bus.bgack && !bgackLast) begin
                tenures <= tenures + 1;
            end
        end
        breqLast  <= bus.breq;
        bgackLast <= bus.bgack;
    end

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checkCount++;
        if (actual !== expected) begin
            $display("ERR %0t: %s: got %h, expected %h", $time, what, actual, expected);
            errCount++;
        end
    endtask

    task automatic regWrite(input logic [1:0] addr, input logic [31:0] data);
        @(posedge CLK135);
        regWr    <= 1'b1;
        regAddr  <= addr;
        regWData <= data;
        @(posedge CLK135);
        regWr <= 1'b0;
    endtask

    task automatic regRead(input logic [1:0] addr, output logic [31:0] data);
        @(posedge CLK135);
        regAddr <= addr;
        @(negedge CLK135);
        data = regRData;
    endtask

    task automatic pushWords(input logic [31:0] first, input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge CLK135);
            periphPush  <= 1'b1;
            periphWData <= first + i;
        end
        @(posedge CLK135);
        periphPush <= 1'b0;
    endtask

    task automatic popWord(output logic [31:0] data);
        @(posedge CLK135);
        periphPop <= 1'b1;
        @(negedge CLK135);
        data = periphRData;  // head before the pop
        @(posedge CLK135);
        periphPop <= 1'b0;
    endtask

    task automatic waitDone(input string what);
        int n;
        n = 0;
        while (!dmaDone && n < DoneWait) begin
            @(negedge CLK135);
            n++;
        end
        if (!dmaDone) begin
            $display("%s: dmaDone did not set within %0d cycles", what, DoneWait);
            errCount++;
        end
    endtask

    task automatic breqQuiet(input int cycles, input string what);
        int  i;
        logic seen;
        seen = 1'b0;
        for (i = 0; i < cycles; i++) begin
            @(negedge CLK135);
            seen = seen | bus.breq;
        end
        checkEq(32'(seen), 32'h0, what);
    endtask

    task automatic endTest(input string name, input int startErr);
        $display("test %s finished with %0d errors", name, errCount - startErr);
    endtask

    task automatic resetAndRegisters();
        int          startErr;
        logic [31:0] rd;
        startErr = errCount;
        checkEq({27'b0, bus}, 32'h0, "bus controls after reset");
        checkEq(32'(dmaDone), 32'h0, "dmaDone after reset");
        regWrite(2'd1, 32'h1000_0040);
        regWrite(2'd2, 32'h0000_1234);
        regWrite(2'd0, 32'h0000_0005);  // flush and dir, not enabled
        regRead(2'd1, rd);
        checkEq(rd, 32'h1000_0040, "base address readback");
        regRead(2'd2, rd);
        checkEq(rd, 32'h0000_1234, "count readback");
        regRead(2'd0, rd);
        checkEq(rd, 32'h0000_0005, "control readback");
        regWrite(2'd0, 32'h0);
        endTest("reset and registers", startErr);
    endtask

    task automatic periphToMemory();
        int startErr;
        int t0;
        int e0;
        int w0;
        int i;
        startErr = errCount;
        t0 = tenures;
        e0 = earlyReq;
        w0 = memWrites;
        regWrite(2'd1, Base2);
        regWrite(2'd2, 32'd8);
        regWrite(2'd0, 32'h2);  // enable, dir 0
        pushWords(32'hD200_0000, 8);
        waitDone("peripheral to memory");
        for (i = 0; i < 8; i++) begin
            checkEq(memRead(Base2 + 4 * i), 32'hD200_0000 + i, $sformatf("memory word %0d", i));
        end
        checkEq(tenures - t0, 2, "bus tenures");
        checkEq(earlyReq - e0, 0, "breq raised below burst level");
        checkEq(memWrites - w0, 8, "memory writes");
        regWrite(2'd0, 32'h0);
        endTest("peripheral to memory", startErr);
    endtask

    task automatic flushPartialBurst();
        int startErr;
        int i;
        startErr = errCount;
        regWrite(2'd1, Base3);
        regWrite(2'd2, 32'd3);
        regWrite(2'd0, 32'h2);
        pushWords(32'hF100_0000, 3);
        breqQuiet(12, "breq with 3 words and no flush");
        regWrite(2'd0, 32'h6);  // enable and flush
        waitDone("flush");
        for (i = 0; i < 3; i++) begin
            checkEq(memRead(Base3 + 4 * i), 32'hF100_0000 + i, $sformatf("flushed word %0d", i));
        end
        checkEq(32'(dmaDone), 32'h1, "dmaDone after flush");
        regWrite(2'd0, 32'h0);
        endTest("flush", startErr);
    endtask

    task automatic memoryToPeriph();
        int          startErr;
        int          i;
        logic [31:0] rd;
        startErr = errCount;
        for (i = 0; i < 4; i++) begin
            memArr[Base4 + 4 * i] = 32'hAB00_0000 ^ (Base4 + 4 * i) ^ (i << 20);
        end
        regWrite(2'd1, Base4);
        regWrite(2'd2, 32'd4);
        regWrite(2'd0, 32'h3);  // enable, dir 1
        waitDone("memory to peripheral");
        for (i = 0; i < 4; i++) begin
            popWord(rd);
            checkEq(rd, 32'hAB00_0000 ^ (Base4 + 4 * i) ^ (i << 20),
                    $sformatf("peripheral word %0d", i));
        end
        regWrite(2'd0, 32'h0);
        endTest("memory to peripheral", startErr);
    endtask

    task automatic completionAndClear();
        int          startErr;
        logic [31:0] rd;
        startErr = errCount;
        regWrite(2'd1, Base5);
        regWrite(2'd2, 32'd4);
        regWrite(2'd0, 32'h2);
        pushWords(32'h5E00_0000, 4);
        waitDone("completion");
        regRead(2'd1, rd);
        checkEq(rd, Base5 + 32'd16, "address after transfer");
        regRead(2'd2, rd);
        checkEq(rd, 32'h0, "count after transfer");
        pushWords(32'h5E00_0010, 4);  // a full burst waiting, count spent
        breqQuiet(20, "breq after completion");
        regRead(2'd0, rd);
        checkEq(32'(rd[3]), 32'h1, "done bit before clear");
        regWrite(2'd0, 32'h0);
        @(negedge CLK135);
        checkEq(32'(dmaDone), 32'h0, "dmaDone after control write");
        endTest("completion", startErr);
    endtask

    initial begin
        seed        = 77;
        ackWait     = $unsigned($random(seed)) % 4;
        ackOut      = 1'b0;
        grantCnt    = 0;
        CCRESET_    = 1'b0;
        regWr       = 1'b0;
        regAddr     = 2'd0;
        regWData    = '0;
        periphPush  = 1'b0;
        periphWData = '0;
        periphPop   = 1'b0;
        bgrant_     = 1'b1;
        dsack_      = 1'b1;
        sterm_      = 1'b1;  // synchronous termination unused
        busDataIn   = '0;
        repeat (5) @(posedge CLK135);
        CCRESET_ <= 1'b1;
        @(negedge CLK135);
        resetAndRegisters();
        periphToMemory();
        flushPartialBurst();
        memoryToPeriph();
        completionAndClear();
        errCount = errCount + dmaTop_i.cpuBusSm_i.cpuBusSmProps.failCount;
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
